//--- flist.f
+incdir+source
source/lcdPkg.sv
source/lcdDelayTimer.sv
source/lcdInitTable.sv
source/lcdNibbleDriver.sv
source/lcdSequencer.sv
source/lcdController.sv
tests/lcdControllerTb.sv

//--- run.sh
#!/bin/sh
# Build and run the LCD controller testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module lcdControllerTb -f flist.f -o lcdSim
./obj_dir/lcdSim | tee sim.log
if grep -qx "NO ERRORS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- tests/lcdControllerTb.sv
`timescale 1ns/1ps
`include "lcd_config.svh"

module lcdControllerTb;

	localparam int CLOCK_PERIOD = 100;
	localparam int BYTE_CYCLES = 2 * `LCD_PULSE_CYCLES + `LCD_HOLD_SHORT + `LCD_HOLD_41US;
	localparam longint INIT_CYCLES = `LCD_POWERON_CYCLES + `LCD_HOLD_4MS + `LCD_HOLD_100US
		+ 5 * `LCD_HOLD_41US + 4 * `LCD_HOLD_SHORT + `LCD_HOLD_CLEAR + 12 * `LCD_PULSE_CYCLES;
	localparam longint RUN_LIMIT = 2 * (INIT_CYCLES + 12 * (BYTE_CYCLES + 4)) * CLOCK_PERIOD;

	logic Clock;
	logic rstN;
	lcdPkg::byte_t charData;
	logic charValid;
	logic readyForData;
	lcdPkg::lcdBus_t lcd;

	int errors = 0;        // Value mismatches and handshake failures
	int monitorErrors = 0; // Pins moving inside a pulse
	int edgeCount = 0;     // Rising edges since start
	int releaseEdge;       // Edge count at reset release
	logic [15:0] lfsr;
	int expNibble [`LCD_INIT_STEPS];
	int expHold [`LCD_INIT_STEPS];
	int pulseRise [$];     // Enable log with one entry per finished pulse
	int pulseLen [$];
	int pulseGap [$];      // Low cycles before the pulse
	int pulseNibble [$];
	int pulseRs [$];
	logic lastEnable = 1'b0;
	int riseEdge = 0;
	int fallEdge = 0;
	lcdPkg::nibble_t riseData;
	logic riseRs;

	lcdController i_dut
	(
		.Clock(Clock),
		.rstN(rstN),
		.charData(charData),
		.charValid(charValid),
		.readyForData(readyForData),
		.lcd(lcd)
	);

	initial
	begin
		Clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) Clock = ~Clock;
	end

	always @(posedge Clock) edgeCount <= edgeCount + 1;

	////////////////////////////////////////////////////////////
	// Pin monitor sampled mid-cycle
	////////////////////////////////////////////////////////////

	always @(negedge Clock)
	begin
		if (lcd.enable && !lastEnable)
		begin
			riseEdge = edgeCount; // Pulse starts
			riseData = lcd.data;
			riseRs = lcd.registerSelect;
		end
		else if (lcd.enable && (lcd.data != riseData || lcd.registerSelect != riseRs))
		begin
			monitorErrors++;
			$display("Data or register select moved during the enable pulse at %0t", $time);
		end
		else if (!lcd.enable && lastEnable)
		begin
			pulseRise.push_back(riseEdge);
			pulseLen.push_back(edgeCount - riseEdge);
			pulseGap.push_back(riseEdge - fallEdge);
			pulseNibble.push_back(int'(riseData));
			pulseRs.push_back(int'(riseRs));
			fallEdge = edgeCount;
		end
		lastEnable = lcd.enable;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic checkValue(input string name, input int expected, input int actual);
		if (expected != actual)
		begin
			errors++;
			$display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
		end
	endtask

	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		return (state >> 1) ^ (state[0] ? 16'hB400 : 16'h0000); // Taps 16 14 13 11
	endfunction

	task automatic nextRandomByte(output lcdPkg::byte_t value);
		value = '0;
		repeat (8)
		begin
			lfsr = lfsrStep(lfsr); // One step per bit
			value = {value[6:0], lfsr[0]};
		end
	endtask

	// Init commands 3 3 3 2, then 28 06 0C 01 in nibbles
	task automatic loadExpectedTable;
		expNibble = '{3, 3, 3, 2, 2, 8, 0, 6, 0, 12, 0, 1};
		expHold = '{`LCD_HOLD_4MS, `LCD_HOLD_100US, `LCD_HOLD_41US, `LCD_HOLD_41US,
			`LCD_HOLD_SHORT, `LCD_HOLD_41US, `LCD_HOLD_SHORT, `LCD_HOLD_41US,
			`LCD_HOLD_SHORT, `LCD_HOLD_41US, `LCD_HOLD_SHORT, `LCD_HOLD_CLEAR};
	endtask

	task automatic verifyRestPins;
		checkValue("lcd.enable", 0, int'(lcd.enable));
		checkValue("lcd.registerSelect", 0, int'(lcd.registerSelect));
		checkValue("lcd.data", 0, int'(lcd.data));
		checkValue("lcd.readWrite", 0, int'(lcd.readWrite));
		checkValue("lcd.flashDisable", 1, int'(lcd.flashDisable));
		checkValue("readyForData", 0, int'(readyForData));
	endtask

	// Polls mid-cycle and returns the edge that raised ready
	task automatic waitReady(input int limit, output int seenEdge);
		int n;
		n = 0;
		seenEdge = -1;
		while (seenEdge < 0 && n < limit)
		begin
			@(negedge Clock);
			if (readyForData)
				seenEdge = edgeCount;
			n++;
		end
		if (seenEdge < 0)
		begin
			errors++;
			$display("readyForData did not rise within %0d cycles at %0t", limit, $time);
		end
	endtask

	// Call 1 ns after a rising edge and charValid stays high
	task automatic offerByte(input lcdPkg::byte_t value, input int limit, output int acceptEdge);
		logic taken;
		int n;
		taken = 1'b0;
		n = 0;
		acceptEdge = -1;
		charData = value;
		charValid = 1'b1;
		while (!taken && n < limit)
		begin
			@(negedge Clock);
			taken = readyForData; // Ready seen before the edge
			@(posedge Clock);
			#1;
			n++;
		end
		if (taken)
			acceptEdge = edgeCount;
		else
		begin
			errors++;
			$display("Byte %0h was not accepted within %0d cycles", value, limit);
		end
	endtask

	task automatic verifyBytePulses(input int base, input lcdPkg::byte_t value,
		input int acceptEdge);
		if (pulseRise.size() < base + 2)
		begin
			errors++;
			$display("Missing enable pulses for byte %0h", value);
			return;
		end
		checkValue("upper pulse start edge", acceptEdge + 1, pulseRise[base]);
		checkValue("lcd.data upper", int'(value[7:4]), pulseNibble[base]);
		checkValue("lcd.data lower", int'(value[3:0]), pulseNibble[base + 1]);
		checkValue("lcd.registerSelect upper", 1, pulseRs[base]);
		checkValue("lcd.registerSelect lower", 1, pulseRs[base + 1]);
		checkValue("upper pulse length", `LCD_PULSE_CYCLES, pulseLen[base]);
		checkValue("lower pulse length", `LCD_PULSE_CYCLES, pulseLen[base + 1]);
		checkValue("gap between nibbles", `LCD_HOLD_SHORT, pulseGap[base + 1]);
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic resetValues;
		repeat (8) @(negedge Clock);
		verifyRestPins(); // Mid reset
		repeat (8) @(posedge Clock);
		#1;
		rstN = 1'b1;
		releaseEdge = edgeCount;
		@(negedge Clock);
		verifyRestPins(); // Just out of reset
	endtask

	task automatic initSequence;
		int readyEdge;
		int delay;
		waitReady(int'(INIT_CYCLES) + 100, readyEdge);
		checkValue("init pulse count", `LCD_INIT_STEPS, pulseRise.size());
		if (pulseRise.size() < `LCD_INIT_STEPS)
			return;
		delay = pulseRise[0] - releaseEdge - 1; // From first edge with rstN high
		if (delay < `LCD_POWERON_CYCLES - 1 || delay > `LCD_POWERON_CYCLES + 1)
		begin
			errors++;
			$display("First enable pulse came %0d cycles after reset release", delay);
		end
		for (int i = 0; i < `LCD_INIT_STEPS; i++)
		begin
			checkValue($sformatf("init nibble %0d", i), expNibble[i], pulseNibble[i]);
			checkValue($sformatf("init registerSelect %0d", i), 0, pulseRs[i]);
			checkValue($sformatf("init pulse length %0d", i), `LCD_PULSE_CYCLES, pulseLen[i]);
			if (i > 0)
				checkValue($sformatf("init gap %0d", i), expHold[i - 1], pulseGap[i]);
		end
		// Enable falls one edge into the clear hold
		checkValue("readyForData after clear", pulseRise[11] + pulseLen[11]
			+ `LCD_HOLD_CLEAR - 1, readyEdge);
	endtask

	task automatic idleQuiet;
		int count;
		count = pulseRise.size();
		repeat (200)
		begin
			@(negedge Clock);
			checkValue("readyForData idle", 1, int'(readyForData));
			checkValue("lcd.enable idle", 0, int'(lcd.enable));
			checkValue("lcd.registerSelect idle", 0, int'(lcd.registerSelect));
			checkValue("lcd.readWrite idle", 0, int'(lcd.readWrite));
			checkValue("lcd.flashDisable idle", 1, int'(lcd.flashDisable));
		end
		checkValue("pulses while idle", count, pulseRise.size());
		@(posedge Clock);
		#1;
	endtask

	task automatic randomBytes;
		lcdPkg::byte_t value;
		int acceptEdge;
		int readyEdge;
		int base;
		repeat (10)
		begin
			nextRandomByte(value);
			base = pulseRise.size();
			offerByte(value, 10, acceptEdge);
			charValid = 1'b0;
			@(negedge Clock);
			checkValue("readyForData busy", 0, int'(readyForData));
			waitReady(BYTE_CYCLES + 10, readyEdge);
			checkValue("readyForData after byte", acceptEdge + BYTE_CYCLES, readyEdge);
			verifyBytePulses(base, value, acceptEdge);
			@(posedge Clock);
			#1;
		end
	endtask

	task automatic backPressure;
		lcdPkg::byte_t first;
		lcdPkg::byte_t second;
		lcdPkg::byte_t junk;
		int firstEdge;
		int secondEdge;
		int readyEdge;
		int base;
		nextRandomByte(first);
		nextRandomByte(second);
		nextRandomByte(junk);
		base = pulseRise.size();
		offerByte(first, 10, firstEdge);
		charData = junk; // Ignored while busy with valid still high
		repeat (1000) @(posedge Clock);
		#1;
		offerByte(second, BYTE_CYCLES + 10, secondEdge);
		charValid = 1'b0;
		charData = ~second;
		checkValue("second accept edge", firstEdge + BYTE_CYCLES + 1, secondEdge);
		waitReady(BYTE_CYCLES + 10, readyEdge);
		checkValue("readyForData after second byte", secondEdge + BYTE_CYCLES, readyEdge);
		repeat (100) @(negedge Clock);
		verifyBytePulses(base, first, firstEdge);
		verifyBytePulses(base + 2, second, secondEdge);
		if (pulseGap.size() > base + 2)
			checkValue("gap before second byte", `LCD_HOLD_41US + 1, pulseGap[base + 2]);
		checkValue("pulses in back-pressure", base + 4, pulseRise.size());
	endtask

	initial
	begin
		rstN = 1'b0;
		charValid = 1'b0;
		charData = '0;
		lfsr = 16'd77;
		loadExpectedTable();
		resetValues();
		initSequence();
		idleQuiet();
		randomBytes();
		backPressure();
		$display("Check errors %0d, monitor errors %0d", errors, monitorErrors);
		if (errors + monitorErrors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Watchdog at twice the expected run length
	initial
	begin
		#(RUN_LIMIT);
		$display("Run timed out after %0d ns", RUN_LIMIT);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- source/lcdController.sv
`timescale 1ns/1ps

// Write-only HD44780 controller, 4-bit bus.
// Runs the init table after power-on, then writes one character
// per ready/valid handshake
module lcdController
(
	input logic Clock,
	input logic rstN,
	input lcdPkg::byte_t charData,     // Character to show
	input logic charValid,             // Held until accepted
	output logic readyForData,         // Transfer when both high
	output lcdPkg::lcdBus_t lcd        // LCD pins
);

	logic timerLoad;                   // Sequencer to timer
	lcdPkg::delay_t timerValue;
	logic timerDone;                   // Timer to sequencer
	lcdPkg::stepIndex_t stepIndex;     // Table row request
	lcdPkg::initStep_t step;           // Table row contents
	logic captureByte;                 // Sequencer to driver
	logic pulseOn;
	logic [1:0] nibbleSelect;
	lcdPkg::nibble_t commandNibble;

	lcdSequencer i_sequencer
	(
		.Clock(Clock),
		.rstN(rstN),
		.charValid(charValid),
		.readyForData(readyForData),
		.timerDone(timerDone),
		.timerLoad(timerLoad),
		.timerValue(timerValue),
		.stepIndex(stepIndex),
		.step(step),
		.captureByte(captureByte),
		.pulseOn(pulseOn),
		.nibbleSelect(nibbleSelect),
		.commandNibble(commandNibble)
	);

	lcdDelayTimer i_timer
	(
		.Clock(Clock),
		.rstN(rstN),
		.timerLoad(timerLoad),
		.timerValue(timerValue),
		.timerDone(timerDone)
	);

	lcdInitTable i_initTable
	(
		.stepIndex(stepIndex),
		.step(step)
	);

	lcdNibbleDriver i_driver
	(
		.Clock(Clock),
		.rstN(rstN),
		.captureByte(captureByte),
		.charData(charData),
		.pulseOn(pulseOn),
		.nibbleSelect(nibbleSelect),
		.commandNibble(commandNibble),
		.lcd(lcd)
	);

endmodule

//--- source/lcdSequencer.sv
`timescale 1ns/1ps
`include "lcd_config.svh"

// Control FSM of the LCD controller.
// Every nibble is a pulse state followed by a hold state, and each state
// reloads the delay timer on entry, so a state lasts exactly its delay.
module lcdSequencer
(
	input logic Clock,
	input logic rstN,
	input logic charValid,                    // Writer has a byte
	output logic readyForData,                // Idle, byte accepted this edge
	input logic timerDone,                    // Current phase ends
	output logic timerLoad,                   // Start next phase
	output lcdPkg::delay_t timerValue,        // Length of next phase
	output lcdPkg::stepIndex_t stepIndex,     // Init table row
	input lcdPkg::initStep_t step,            // Row contents
	output logic captureByte,                 // Latch the character
	output logic pulseOn,                     // Enable request
	output logic [1:0] nibbleSelect,          // Nibble source
	output lcdPkg::nibble_t commandNibble     // Table nibble or zero
);

	lcdPkg::seqState_t state;     // Current phase
	lcdPkg::seqState_t nextState;
	logic armed;                  // Power-on delay loaded
	logic advanceStep;            // Move to next table row
	logic inInit;                 // Walking the table

	////////////////////////////////////////////////////////////
	// Next state and timer loads
	////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		timerLoad = 1'b0;
		timerValue = lcdPkg::delay_t'(`LCD_PULSE_CYCLES); // Most loads start a pulse
		advanceStep = 1'b0;
		captureByte = 1'b0;
		case (state)
			lcdPkg::stPowerOn:
			begin
				if (!armed)
				begin
					timerLoad = 1'b1; // First edge out of reset
					timerValue = lcdPkg::delay_t'(`LCD_POWERON_CYCLES - 1); // Output reg adds one
				end
				else if (timerDone)
				begin
					timerLoad = 1'b1;
					nextState = lcdPkg::stInitPulse;
				end
			end
			lcdPkg::stInitPulse:
			begin
				if (timerDone)
				begin
					timerLoad = 1'b1;
					timerValue = step.hold; // Hold from the table row
					nextState = lcdPkg::stInitHold;
				end
			end
			lcdPkg::stInitHold:
			begin
				if (timerDone)
				begin
					if (stepIndex == lcdPkg::stepIndex_t'(`LCD_INIT_STEPS - 1))
					begin
						nextState = lcdPkg::stIdle; // Table done, timer stays empty
					end
					else
					begin
						timerLoad = 1'b1;
						advanceStep = 1'b1;
						nextState = lcdPkg::stInitPulse;
					end
				end
			end
			lcdPkg::stIdle:
			begin
				if (charValid)
				begin
					timerLoad = 1'b1;   // Handshake completes here
					captureByte = 1'b1;
					nextState = lcdPkg::stUpperPulse;
				end
			end
			lcdPkg::stUpperPulse:
			begin
				if (timerDone)
				begin
					timerLoad = 1'b1;
					timerValue = lcdPkg::delay_t'(`LCD_HOLD_SHORT); // Between nibbles
					nextState = lcdPkg::stUpperHold;
				end
			end
			lcdPkg::stUpperHold:
			begin
				if (timerDone)
				begin
					timerLoad = 1'b1;
					nextState = lcdPkg::stLowerPulse;
				end
			end
			lcdPkg::stLowerPulse:
			begin
				if (timerDone)
				begin
					timerLoad = 1'b1;
					timerValue = lcdPkg::delay_t'(`LCD_HOLD_41US); // Character write time
					nextState = lcdPkg::stLowerHold;
				end
			end
			default:
			begin
				if (timerDone)
				begin
					nextState = lcdPkg::stIdle; // Lower hold over
				end
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// State registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= lcdPkg::stPowerOn;
			armed <= 1'b0;
			stepIndex <= '0;
		end
		else
		begin
			state <= nextState;
			armed <= 1'b1; // Set once after reset
			if (advanceStep)
			begin
				stepIndex <= stepIndex + lcdPkg::stepIndex_t'(1);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs from state
	////////////////////////////////////////////////////////////

	assign inInit = (state == lcdPkg::stInitPulse) || (state == lcdPkg::stInitHold);
	assign readyForData = (state == lcdPkg::stIdle);

	assign pulseOn = (state == lcdPkg::stInitPulse) || (state == lcdPkg::stUpperPulse)
		|| (state == lcdPkg::stLowerPulse);

	always_comb
	begin
		case (state)
			lcdPkg::stUpperPulse, lcdPkg::stUpperHold: nibbleSelect = `LCD_SEL_UPPER;
			lcdPkg::stLowerPulse, lcdPkg::stLowerHold: nibbleSelect = `LCD_SEL_LOWER;
			default: nibbleSelect = `LCD_SEL_COMMAND; // Init, power-on, idle
		endcase
	end

	// Data pins rest at zero outside the table walk
	assign commandNibble = inInit ? step.nibble : '0;

endmodule

//--- source/lcdNibbleDriver.sv
`timescale 1ns/1ps
`include "lcd_config.svh"

// Output register for the LCD pins.
// Holds the accepted character and puts the selected nibble,
// register select and enable on the bus one cycle after the request
module lcdNibbleDriver
(
	input logic Clock,
	input logic rstN,
	input logic captureByte,                 // Latch charData this edge
	input lcdPkg::byte_t charData,           // Character from the writer
	input logic pulseOn,                     // Enable high next cycle
	input logic [1:0] nibbleSelect,          // Command, upper or lower
	input lcdPkg::nibble_t commandNibble,    // From the init table
	output lcdPkg::lcdBus_t lcd              // Registered LCD pins
);

	lcdPkg::byte_t heldByte;     // Character being written
	lcdPkg::nibble_t dataNibble; // Chosen nibble, before the register
	lcdPkg::lcdBus_t nextBus;    // Pin values for the next cycle

	// Character latch for the accepted byte
	always_ff @(posedge Clock)
	begin
		if (captureByte)
		begin
			heldByte <= charData;
		end
	end

	////////////////////////////////////////////////////////////
	// Nibble choice
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (nibbleSelect)
			`LCD_SEL_UPPER: dataNibble = heldByte[7:4]; // Sent first
			`LCD_SEL_LOWER: dataNibble = heldByte[3:0];
			default: dataNibble = commandNibble;        // Init table
		endcase
	end

	always_comb
	begin
		nextBus.enable = pulseOn;
		nextBus.registerSelect = (nibbleSelect != `LCD_SEL_COMMAND); // Data register
		nextBus.readWrite = 1'b0;    // Write only
		nextBus.flashDisable = 1'b1; // Flash off the shared bus
		nextBus.data = dataNibble;
	end

	////////////////////////////////////////////////////////////
	// Pin register
	////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			lcd.enable <= 1'b0;
			lcd.registerSelect <= 1'b0;
			lcd.readWrite <= 1'b0;
			lcd.flashDisable <= 1'b1; // Flash disabled from reset on
			lcd.data <= '0;
		end
		else
		begin
			lcd <= nextBus; // Data and enable change together
		end
	end

endmodule

//--- source/lcdInitTable.sv
`timescale 1ns/1ps
`include "lcd_config.svh"

// Command nibbles played after power-on.
// Rows 0..3 wake the controller and switch it to 4-bit mode,
// then 28, 06, 0C and 01 follow as upper and lower nibbles
module lcdInitTable
(
	input lcdPkg::stepIndex_t stepIndex, // Row to read
	output lcdPkg::initStep_t step       // Nibble and its hold
);

	always_comb
	begin
		case (stepIndex)
			////////////////////////////////////////////////////////////
			// Wake-up, still in 8-bit mode
			////////////////////////////////////////////////////////////
			4'd0: step = '{nibble: 4'h3, hold: lcdPkg::delay_t'(`LCD_HOLD_4MS)};
			4'd1: step = '{nibble: 4'h3, hold: lcdPkg::delay_t'(`LCD_HOLD_100US)};
			4'd2: step = '{nibble: 4'h3, hold: lcdPkg::delay_t'(`LCD_HOLD_41US)};
			4'd3: step = '{nibble: 4'h2, hold: lcdPkg::delay_t'(`LCD_HOLD_41US)}; // Go 4-bit

			////////////////////////////////////////////////////////////
			// Byte commands, upper then lower nibble
			////////////////////////////////////////////////////////////

			// Function set 28, two lines, 5x8 font
			4'd4: step = '{nibble: 4'h2, hold: lcdPkg::delay_t'(`LCD_HOLD_SHORT)};
			4'd5: step = '{nibble: 4'h8, hold: lcdPkg::delay_t'(`LCD_HOLD_41US)};

			// Entry mode 06, cursor moves right
			4'd6: step = '{nibble: 4'h0, hold: lcdPkg::delay_t'(`LCD_HOLD_SHORT)};
			4'd7: step = '{nibble: 4'h6, hold: lcdPkg::delay_t'(`LCD_HOLD_41US)};

			// Display control 0C, display on, no cursor
			4'd8: step = '{nibble: 4'h0, hold: lcdPkg::delay_t'(`LCD_HOLD_SHORT)};
			4'd9: step = '{nibble: 4'hC, hold: lcdPkg::delay_t'(`LCD_HOLD_41US)};

			// Clear display 01, slow command
			4'd10: step = '{nibble: 4'h0, hold: lcdPkg::delay_t'(`LCD_HOLD_SHORT)};
			4'd11: step = '{nibble: 4'h1, hold: lcdPkg::delay_t'(`LCD_HOLD_CLEAR)};

			default:
			begin
				step = '{nibble: 4'h0, hold: lcdPkg::delay_t'(`LCD_HOLD_SHORT)}; // Past the end
			end
		endcase
	end

endmodule

//--- source/lcdDelayTimer.sv
`timescale 1ns/1ps

// Down-counter for pulse and hold lengths.
// A load of N gives timerDone in the Nth cycle after the load edge,
// so a state that reloads on timerDone lasts exactly N cycles.
module lcdDelayTimer
(
	input logic Clock,
	input logic rstN,
	input logic timerLoad,              // Start a new delay
	input lcdPkg::delay_t timerValue,   // Length in cycles
	output logic timerDone              // Last cycle of the delay
);

	lcdPkg::delay_t count; // Cycles left, zero when empty

	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			count <= '0; // Empty after reset
		end
		else if (timerLoad)
		begin
			count <= timerValue; // Load wins over counting
		end
		else if (count != '0)
		begin
			count <= count - lcdPkg::delay_t'(1);
		end
	end

	// One cycle flag, stays low while empty
	assign timerDone = (count == lcdPkg::delay_t'(1));

endmodule

//--- source/lcdPkg.sv
`include "lcd_config.svh"

package lcdPkg;

	////////////////////////////////////////////////////////////
	// Plain vectors
	////////////////////////////////////////////////////////////

	typedef logic [3:0] nibble_t;                   // LCD data pins
	typedef logic [7:0] byte_t;                     // Character code
	typedef logic [`LCD_DELAY_BITS-1:0] delay_t;    // Cycle count
	typedef logic [3:0] stepIndex_t;                // Init table row

	////////////////////////////////////////////////////////////
	// Structs
	////////////////////////////////////////////////////////////

	// One row of the init table
	typedef struct packed {
		nibble_t nibble; // Value on the data pins
		delay_t hold;    // Enable-low time after the pulse
	} initStep_t;

	// Pins of the LCD, write only
	typedef struct packed {
		logic enable;         // Latches on falling edge
		logic registerSelect; // 0 command, 1 data
		logic readWrite;      // Always write
		logic flashDisable;   // Keeps the StrataFlash off the bus
		nibble_t data;        // Upper four data pins
	} lcdBus_t;

	////////////////////////////////////////////////////////////
	// Sequencer states
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		stPowerOn,    // Waiting for supply to settle
		stInitPulse,  // Enable high, table nibble
		stInitHold,   // Enable low, table hold
		stIdle,       // Ready for a byte
		stUpperPulse, // Enable high, data bits 7:4
		stUpperHold,
		stLowerPulse, // Enable high, data bits 3:0
		stLowerHold
	} seqState_t;

endpackage

//--- source/lcd_config.svh
`ifndef LCD_CONFIG_SVH
`define LCD_CONFIG_SVH

////////////////////////////////////////////////////////////
// Timing in clock cycles, 50 MHz clock
////////////////////////////////////////////////////////////

// Wait after power-up before the first nibble, 15 ms
`define LCD_POWERON_CYCLES 750000

// Enable high time for every nibble
`define LCD_PULSE_CYCLES 15

// Hold after an upper nibble, about 1.2 us
`define LCD_HOLD_SHORT 60

`define LCD_HOLD_41US 2050   // Normal command and data settle
`define LCD_HOLD_100US 5000  // Second wake-up nibble
`define LCD_HOLD_4MS 205000  // First wake-up nibble
`define LCD_HOLD_CLEAR 82500 // Clear display, 1.65 ms

////////////////////////////////////////////////////////////
// Sizes
////////////////////////////////////////////////////////////

`define LCD_INIT_STEPS 12 // Nibbles in the init table
`define LCD_DELAY_BITS 20 // Holds the power-on count

////////////////////////////////////////////////////////////
// Nibble source select, sequencer to driver
////////////////////////////////////////////////////////////

`define LCD_SEL_COMMAND 2'd0 // Nibble from init table
`define LCD_SEL_UPPER 2'd1   // Bits 7:4 of held byte
`define LCD_SEL_LOWER 2'd2   // Bits 3:0 of held byte

`endif
